// ==== files.f ====
+incdir+include
logic/layernorm_pkg.sv
logic/sdram_read_master.sv
logic/layernorm_fetch.sv
logic/layernorm_param_regs.sv
logic/layernorm_affine.sv
logic/layernorm_top.sv
tests/clock_gen.sv
tests/mem_model.sv
tests/tb_layernorm.sv

// ==== include/layernorm_defs.svh ====
`ifndef LAYERNORM_DEFS_SVH
`define LAYERNORM_DEFS_SVH

// lanes per vector, one int8 each.
`define LN_N 16

// one memory beat.
`define LN_BEAT_W 32

// beats needed for one parameter line.
`define LN_BLK_NUM ((`LN_N * 8) / `LN_BEAT_W)

// byte stride between consecutive parameter lines.
`define LN_LINE_BYTES (`LN_BLK_NUM * 4)

// gamma is fixed point with this many fraction bits.
`define LN_GAMMA_FRAC 8

`endif

// ==== logic/layernorm_affine.sv ====
`include "layernorm_defs.svh"

module layernorm_affine (
    input  logic                    clk,
    input  logic                    rst_n,
    input  layernorm_pkg::ln_vec_t  i_sample,
    input  logic [`LN_N-1:0][15:0]  i_gamma,
    input  logic [`LN_N-1:0][7:0]   i_beta,
    output layernorm_pkg::ln_vec_t  o_result
);

    import layernorm_pkg::*;

    localparam int PROD_W = 24; // int8 times int16.
    localparam int SUM_W  = PROD_W + 1;

    logic [`LN_N-1:0][PROD_W-1:0] prod_q;
    logic [`LN_N-1:0][7:0]        beta_q;
    logic                         valid_q;
    logic [`LN_N-1:0][7:0]        sat;
    ln_vec_t                      res_q;

    // stage 1, products against the current parameters.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_q  <= '0;
            beta_q  <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_sample.valid;
            beta_q  <= i_beta;
            for (int i = 0; i < `LN_N; i++) begin
                prod_q[i] <= PROD_W'($signed(i_sample.lane[i]) * $signed(i_gamma[i]));
            end
        end
    end

    // stage 2 math, rescale then add beta and clamp.
    always_comb begin
        for (int i = 0; i < `LN_N; i++) begin
            logic signed [SUM_W-1:0] sum;
            sum = SUM_W'($signed(prod_q[i]) >>> `LN_GAMMA_FRAC) + SUM_W'($signed(beta_q[i]));
            if (sum > SUM_W'(127)) begin
                sat[i] = 8'h7f;
            end else if (sum < -SUM_W'(128)) begin
                sat[i] = 8'h80;
            end else begin
                sat[i] = sum[7:0];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_q <= '0;
        end else begin
            res_q.valid <= valid_q;
            res_q.lane  <= sat;
        end
    end

    assign o_result = res_q;

endmodule

// ==== logic/layernorm_fetch.sv ====
`include "layernorm_defs.svh"

module layernorm_fetch (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_start,
    input  logic [31:0]             i_fetch_addr,
    output logic                    o_done,
    output logic                    o_read_start,
    output layernorm_pkg::rd_cmd_t  o_cmd,
    input  logic                    i_read_valid,
    input  logic [`LN_BEAT_W-1:0]   i_read_data,
    input  logic                    i_read_done,
    output logic [`LN_N*8-1:0]      o_line,
    output logic                    o_gamma_lo_valid,
    output logic                    o_gamma_hi_valid,
    output logic                    o_beta_valid
);

    localparam int BLK_W = $clog2(`LN_BLK_NUM);

    typedef enum logic [2:0] {
        IDLE,
        GLO_SEND,
        GLO_RECV,
        GHI_SEND,
        GHI_RECV,
        BETA_SEND,
        BETA_RECV
    } state_t;

    state_t state;
    state_t nxt_state;

    logic                                  start_ok;
    logic                                  line_done;
    logic                                  recv;
    logic [31:0]                           addr_q;
    logic [BLK_W-1:0]                      blk_cnt;
    logic [`LN_BLK_NUM-1:0][`LN_BEAT_W-1:0] line_q;
    logic [`LN_BLK_NUM-1:0][`LN_BEAT_W-1:0] line_out;

    assign start_ok  = (state == IDLE) && i_start; // ignored while busy.
    assign recv      = (state == GLO_RECV) || (state == GHI_RECV) || (state == BETA_RECV);
    assign line_done = recv && i_read_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (start_ok) begin
            addr_q <= i_fetch_addr;
        end else if (line_done) begin
            addr_q <= addr_q + 32'(`LN_LINE_BYTES); // next line.
        end
    end

    assign o_cmd.addr = addr_q;
    assign o_cmd.cnt  = 8'(`LN_BLK_NUM);

    // beat placement into the line buffer.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blk_cnt <= '0;
            line_q  <= '0;
        end else if (start_ok) begin
            blk_cnt <= '0;
        end else if (recv && i_read_valid) begin
            blk_cnt         <= blk_cnt + 1'b1; // wraps at line end.
            line_q[blk_cnt] <= i_read_data;
        end
    end

    // last beat bypasses the buffer so the line is whole on the valid pulse.
    always_comb begin
        line_out = line_q;
        if (recv && i_read_valid) begin
            line_out[blk_cnt] = i_read_data;
        end
    end

    assign o_line = line_out;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state        = state;
        o_done           = 1'b0;
        o_read_start     = 1'b0;
        o_gamma_lo_valid = 1'b0;
        o_gamma_hi_valid = 1'b0;
        o_beta_valid     = 1'b0;
        case (state)
            IDLE: begin
                o_done = 1'b1;
                if (i_start) nxt_state = GLO_SEND;
            end
            GLO_SEND: begin
                o_read_start = 1'b1;
                nxt_state    = GLO_RECV;
            end
            GLO_RECV: begin
                o_gamma_lo_valid = i_read_done;
                if (i_read_done) nxt_state = GHI_SEND;
            end
            GHI_SEND: begin
                o_read_start = 1'b1;
                nxt_state    = GHI_RECV;
            end
            GHI_RECV: begin
                o_gamma_hi_valid = i_read_done;
                if (i_read_done) nxt_state = BETA_SEND;
            end
            BETA_SEND: begin
                o_read_start = 1'b1;
                nxt_state    = BETA_RECV;
            end
            default: begin // beta line.
                o_beta_valid = i_read_done;
                if (i_read_done) nxt_state = IDLE;
            end
        endcase
    end

endmodule

// ==== logic/layernorm_param_regs.sv ====
`include "layernorm_defs.svh"

module layernorm_param_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`LN_N*8-1:0]       i_line,
    input  logic                     i_gamma_lo_valid,
    input  logic                     i_gamma_hi_valid,
    input  logic                     i_beta_valid,
    output logic [`LN_N-1:0][15:0]   o_gamma,
    output logic [`LN_N-1:0][7:0]    o_beta
);

    logic [`LN_N-1:0][7:0] gamma_lo_q;
    logic [`LN_N-1:0][7:0] gamma_hi_q;
    logic [`LN_N-1:0][7:0] beta_q;

    // each bank loads on its own pulse.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gamma_lo_q <= '0;
            gamma_hi_q <= '0;
            beta_q     <= '0;
        end else begin
            if (i_gamma_lo_valid) gamma_lo_q <= i_line;
            if (i_gamma_hi_valid) gamma_hi_q <= i_line;
            if (i_beta_valid)     beta_q     <= i_line;
        end
    end

    // signed q8.8 gamma per lane, high byte carries the sign.
    always_comb begin
        for (int i = 0; i < `LN_N; i++) begin
            o_gamma[i] = {gamma_hi_q[i], gamma_lo_q[i]};
        end
    end

    assign o_beta = beta_q;

endmodule

// ==== logic/layernorm_pkg.sv ====
`include "layernorm_defs.svh"

package layernorm_pkg;

    // burst read command to the read master.
    typedef struct packed {
        logic [31:0] addr; // start byte address.
        logic [7:0]  cnt;  // beats in the burst.
    } rd_cmd_t;

    // single-beat request to memory.
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } mem_req_t;

    // memory response, one beat.
    typedef struct packed {
        logic                  valid;
        logic [`LN_BEAT_W-1:0] data;
    } mem_rsp_t;

    // int8 sample vector, lane 0 in the low byte.
    typedef struct packed {
        logic                  valid;
        logic [`LN_N-1:0][7:0] lane;
    } ln_vec_t;

endpackage

// ==== logic/layernorm_top.sv ====
`include "layernorm_defs.svh"

module layernorm_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     i_start,
    input  logic [31:0]              i_fetch_addr,
    output logic                     o_done,
    output layernorm_pkg::mem_req_t  o_mem_req,
    input  layernorm_pkg::mem_rsp_t  i_mem_rsp,
    input  layernorm_pkg::ln_vec_t   i_sample,
    output layernorm_pkg::ln_vec_t   o_result
);

    import layernorm_pkg::*;

    rd_cmd_t               cmd;
    logic                  read_start;
    logic                  read_valid;
    logic [`LN_BEAT_W-1:0] read_data;
    logic                  read_done;
    logic [`LN_N*8-1:0]    line;
    logic                  gamma_lo_valid;
    logic                  gamma_hi_valid;
    logic                  beta_valid;
    logic [`LN_N-1:0][15:0] gamma;
    logic [`LN_N-1:0][7:0]  beta;

    sdram_read_master sdram_read_master_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_read_start (read_start),
        .i_cmd        (cmd),
        .o_read_valid (read_valid),
        .o_read_data  (read_data),
        .o_read_done  (read_done),
        .o_mem_req    (o_mem_req),
        .i_mem_rsp    (i_mem_rsp)
    );

    layernorm_fetch layernorm_fetch_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_start          (i_start),
        .i_fetch_addr     (i_fetch_addr),
        .o_done           (o_done),
        .o_read_start     (read_start),
        .o_cmd            (cmd),
        .i_read_valid     (read_valid),
        .i_read_data      (read_data),
        .i_read_done      (read_done),
        .o_line           (line),
        .o_gamma_lo_valid (gamma_lo_valid),
        .o_gamma_hi_valid (gamma_hi_valid),
        .o_beta_valid     (beta_valid)
    );

    layernorm_param_regs layernorm_param_regs_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_line           (line),
        .i_gamma_lo_valid (gamma_lo_valid),
        .i_gamma_hi_valid (gamma_hi_valid),
        .i_beta_valid     (beta_valid),
        .o_gamma          (gamma),
        .o_beta           (beta)
    );

    layernorm_affine layernorm_affine_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_sample (i_sample),
        .i_gamma  (gamma),
        .i_beta   (beta),
        .o_result (o_result)
    );

endmodule

// ==== logic/sdram_read_master.sv ====
`include "layernorm_defs.svh"

module sdram_read_master (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     i_read_start,
    input  layernorm_pkg::rd_cmd_t   i_cmd,
    output logic                     o_read_valid,
    output logic [`LN_BEAT_W-1:0]    o_read_data,
    output logic                     o_read_done,
    output layernorm_pkg::mem_req_t  o_mem_req,
    input  layernorm_pkg::mem_rsp_t  i_mem_rsp
);

    logic [31:0] req_addr;
    logic [7:0]  req_left; // requests still to issue.
    logic [7:0]  rsp_left; // beats still to come back.
    logic        req_fire;

    assign req_fire = (req_left != 8'd0);

    // request side, one beat per cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_addr <= '0;
            req_left <= '0;
        end else if (i_read_start) begin
            req_addr <= i_cmd.addr;
            req_left <= i_cmd.cnt;
        end else if (req_fire) begin
            req_addr <= req_addr + 32'(`LN_BEAT_W / 8); // next word.
            req_left <= req_left - 8'd1;
        end
    end

    assign o_mem_req.valid = req_fire;
    assign o_mem_req.addr  = req_addr;

    // response side, counts returned beats.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_left <= '0;
        end else if (i_read_start) begin
            rsp_left <= i_cmd.cnt;
        end else if (o_read_valid) begin
            rsp_left <= rsp_left - 8'd1;
        end
    end

    // stray beats outside a burst are dropped.
    assign o_read_valid = i_mem_rsp.valid && (rsp_left != 8'd0);
    assign o_read_data  = i_mem_rsp.data;
    assign o_read_done  = o_read_valid && (rsp_left == 8'd1); // last beat.

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_layernorm -o sim_layernorm
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_layernorm 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "STATUS: PASS"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

// ==== tests/clock_gen.sv ====
module clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // period 8.
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1; // released just after the 4th edge.
    end

endmodule

// ==== tests/mem_model.sv ====
`include "layernorm_defs.svh"

module mem_model (
    input  logic                     clk,
    input  logic                     rst_n,
    input  layernorm_pkg::mem_req_t  i_req,
    output layernorm_pkg::mem_rsp_t  o_rsp
);

    import layernorm_pkg::*;

    logic        valid_d1;
    logic [31:0] addr_d1;
    mem_rsp_t    rsp_q;

    // two xorshift rounds over seed and address.
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        logic [31:0] x;
        x = 32'd56183 ^ addr;
        for (int r = 0; r < 2; r++) begin
            x = x ^ (x << 13);
            x = x ^ (x >> 17);
            x = x ^ (x << 5);
        end
        return x;
    endfunction

    // fixed latency of 2 cycles.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_d1 <= 1'b0;
            addr_d1  <= '0;
            rsp_q    <= '0;
        end else begin
            valid_d1    <= i_req.valid;
            addr_d1     <= i_req.addr;
            rsp_q.valid <= valid_d1;
            rsp_q.data  <= valid_d1 ? word_at(addr_d1) : '0;
        end
    end

    assign o_rsp = rsp_q;

endmodule

// ==== tests/tb_layernorm.sv ====
`include "layernorm_defs.svh"

module tb_layernorm;

    import layernorm_pkg::*;

    localparam int N_FETCH   = 2;
    localparam int N_SAMPLES = 113;
    localparam int FETCH_CYC = 40; // three lines of a few cycles each.
    localparam int MARGIN    = 60;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic [31:0] fetch_addr;
    logic        done;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;
    ln_vec_t     sample;
    ln_vec_t     result;

    logic [31:0]           rng = 32'd56183;
    logic [31:0]           req_q[$]; // expected request addresses.
    ln_vec_t               exp_q[$];
    int                    due_q[$];
    logic [`LN_N-1:0][7:0] g_lo = '0; // reference copy of the parameters.
    logic [`LN_N-1:0][7:0] g_hi = '0;
    logic [`LN_N-1:0][7:0] b_m = '0;
    logic [31:0]           base = '0;
    int                    beats = 3 * `LN_BLK_NUM;
    int                    cycle = 0;
    int                    n_hi = 0;
    int                    n_lo = 0;
    logic                  busy = 1'b0; // a fetch is in flight.

    clock_gen clock_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mem_model mem_model_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .i_req (mem_req),
        .o_rsp (mem_rsp)
    );

    layernorm_top layernorm_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_start      (start),
        .i_fetch_addr (fetch_addr),
        .o_done       (done),
        .o_mem_req    (mem_req),
        .i_mem_rsp    (mem_rsp),
        .i_sample     (sample),
        .o_result     (result)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // memory contents, recomputed from the address.
    function automatic logic [`LN_N*8-1:0] line_bytes(input logic [31:0] addr);
        logic [`LN_N*8-1:0] l;
        for (int k = 0; k < `LN_BLK_NUM; k++) begin
            l[32*k +: 32] = xorshift32(xorshift32(32'd56183 ^ (addr + 32'(4 * k))));
        end
        return l;
    endfunction

    // q8.8 gamma, shift, add beta, clamp to int8.
    function automatic logic [7:0] affine_lane(input logic [7:0] x, input logic [15:0] g,
                                               input logic [7:0] b);
        int v;
        v = ((int'($signed(x)) * int'($signed(g))) >>> `LN_GAMMA_FRAC) + int'($signed(b));
        if (v > 127) return 8'h7f;
        if (v < -128) return 8'h80;
        return v[7:0];
    endfunction

    function automatic ln_vec_t rand_vec();
        ln_vec_t v;
        for (int k = 0; k < `LN_N / 4; k++) begin
            v.lane[k*4 +: 4] = rand32();
        end
        v.valid = (rand32() % 32'd4) != 32'd0; // mostly back to back.
        return v;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp)
            else fail_now($sformatf("FAILED t=%0t %s got %b expected %b",
                                    $time, name, got, exp));
    endtask

    task automatic step(input logic st, input logic [31:0] addr, input ln_vec_t s);
        @(posedge clk);
        #1;
        start      = st;
        fetch_addr = addr;
        sample     = s;
    endtask

    task automatic wait_done();
        while (!done) step(1'b0, 32'd0, '0);
    endtask

    task automatic send_random(input int n);
        repeat (n) step(1'b0, 32'd0, rand_vec());
    endtask

    // lanes pushed past both int8 limits.
    task automatic send_saturating();
        ln_vec_t hi;
        ln_vec_t lo;
        hi.valid = 1'b1;
        lo.valid = 1'b1;
        for (int i = 0; i < `LN_N; i++) begin
            hi.lane[i] = g_hi[i][7] ? 8'h80 : 8'h7f; // same sign as gamma.
            lo.lane[i] = g_hi[i][7] ? 8'h7f : 8'h80;
        end
        step(1'b0, 32'd0, hi);
        step(1'b0, 32'd0, lo);
    endtask

    always @(posedge clk) cycle <= cycle + 1;

    always @(negedge clk) begin : monitor
        ln_vec_t            e;
        logic [`LN_N*8-1:0] lbuf;
        if (!rst_n) begin
            check_bit("o_done", done, 1'b1);
            check_bit("o_mem_req.valid", mem_req.valid, 1'b0);
            check_bit("o_result.valid", result.valid, 1'b0);
        end else begin
            // low from the cycle after start until the beta line is in.
            check_bit("o_done", done, !busy);
            if (mem_req.valid) begin
                assert (req_q.size() > 0)
                    else fail_now("memory request issued while none was expected");
                assert (mem_req.addr === req_q[0])
                    else fail_now($sformatf("FAILED t=%0t o_mem_req.addr got %h expected %h",
                                            $time, mem_req.addr, req_q[0]));
                void'(req_q.pop_front());
            end
            if (due_q.size() > 0 && due_q[0] == cycle) begin
                check_bit("o_result.valid", result.valid, 1'b1);
                assert (result.lane === exp_q[0].lane)
                    else fail_now($sformatf("FAILED t=%0t o_result.lane got %h expected %h",
                                            $time, result.lane, exp_q[0].lane));
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end else begin
                check_bit("o_result.valid", result.valid, 1'b0);
            end
            // stage 1 sees the parameters held in this cycle.
            if (sample.valid) begin
                e.valid = 1'b1;
                for (int i = 0; i < `LN_N; i++) begin
                    e.lane[i] = affine_lane(sample.lane[i], {g_hi[i], g_lo[i]}, b_m[i]);
                    if (e.lane[i] == 8'h7f) n_hi++;
                    if (e.lane[i] == 8'h80) n_lo++;
                end
                exp_q.push_back(e);
                due_q.push_back(cycle + 2);
            end
            // a line is captured at the end of its last beat.
            if (mem_rsp.valid && beats < 3 * `LN_BLK_NUM) begin
                if (beats % `LN_BLK_NUM == `LN_BLK_NUM - 1) begin
                    lbuf = line_bytes(base + 32'(`LN_LINE_BYTES * (beats / `LN_BLK_NUM)));
                    if (beats / `LN_BLK_NUM == 0) g_lo = lbuf;
                    else if (beats / `LN_BLK_NUM == 1) g_hi = lbuf;
                    else begin
                        b_m  = lbuf;
                        busy = 1'b0; // done is back next cycle.
                    end
                end
                beats++;
            end
            if (start && done) begin // accepted start only.
                base  = fetch_addr;
                beats = 0;
                busy  = 1'b1;
                for (int k = 0; k < 3 * `LN_BLK_NUM; k++) begin
                    req_q.push_back(fetch_addr + 32'(4 * k));
                end
            end
        end
    end

    initial begin
        #((N_FETCH * FETCH_CYC + N_SAMPLES + MARGIN) * 8);
        fail_now("the run timed out before all tests finished");
    end

    initial begin
        start      = 1'b0;
        fetch_addr = 32'd0;
        sample     = '0;
        @(posedge rst_n);
        step(1'b1, 32'h0000_1000, '0);
        repeat (3) step(1'b0, 32'd0, '0);
        step(1'b1, 32'h0000_7f00, '0); // busy, must be ignored.
        wait_done();
        send_random(40);
        send_saturating();
        // second fetch with traffic running through it.
        step(1'b1, 32'h0004_2a40, rand_vec());
        send_random(30);
        wait_done();
        send_random(40);
        repeat (4) step(1'b0, 32'd0, '0);
        assert (req_q.size() == 0 && exp_q.size() == 0)
            else fail_now("expected requests or results were still pending at the end");
        assert (n_hi > 0 && n_lo > 0)
            else fail_now("no lane was driven into saturation at both limits");
        $display("STATUS: PASS");
        $finish;
    end

endmodule
